/* line_buffer.sv */
// line memory, one write port from the renderer and one read port
// for the display; read data is registered, no read-during-write bypass
`timescale 1ns/10ps
`include "tilemap_defines.svh"

module line_buffer import tilemap_pkg::*; (
    input  logic      clk,
    input  logic      buf_wr,
    input  buf_addr_t buf_addr,
    input  pixel_t    buf_data,
    input  buf_addr_t rd_addr,
    output pixel_t    rd_data
);

    pixel_t mem [0:`BUF_DEPTH-1];

    always_ff @(posedge clk) begin
        if (buf_wr)
            mem[buf_addr] <= buf_data;
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];    // one cycle read latency
    end

endmodule

/* pixel_unpacker.sv */
// planar row shifter and line buffer write address
// the write address wraps, so leading fine-scroll pixels land at the top
`timescale 1ns/10ps
`include "tilemap_defines.svh"

module pixel_unpacker import tilemap_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  scroll_regs_s regs,
    input  logic         line_load,
    input  logic         row_load,
    input  logic         pix_shift,
    input  gfx_row_t     rom_data,
    input  tile_attr_s   attr,
    output logic         buf_wr,
    output buf_addr_t    buf_addr,
    output pixel_t       buf_data,
    output logic         line_end
);

    gfx_row_t  row;
    logic [3:0] colour;
    buf_addr_t addr_nxt;

    // one bit per plane, taken from the end that leaves the shifter first
    assign colour = attr.hflip ? {row[24], row[16], row[8], row[0]}
                               : {row[31], row[23], row[15], row[7]};

    assign buf_wr   = pix_shift;
    assign buf_data = {attr.pal, colour};
    assign addr_nxt = buf_addr + 9'd1;

    always_ff @(posedge clk) begin
        if (row_load)
            row <= rom_data;
        else if (pix_shift)
            row <= attr.hflip ? row >> 1 : row << 1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            buf_addr <= '0;
            line_end <= 1'b0;
        end else if (line_load) begin
            buf_addr <= 9'd0 - {6'd0, regs.hpos[2:0]};  // fine scroll
            line_end <= 1'b0;
        end else if (pix_shift) begin
            buf_addr <= addr_nxt;
            if (addr_nxt == buf_addr_t'(`LINE_PIXELS - 1))
                line_end <= 1'b1;   // last pixel of the line is in this tile or the next
        end
    end

endmodule

/* run_sim.sh */
#!/bin/bash
# build and run the tile layer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_tilemap
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_tilemap)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulator returned status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation completed successfully$"; then
    exit 0
fi
exit 1

/* tb_tilemap.sv */
// line renderer testbench; VRAM and ROM are behavioral models with random ok delay
// tests, scroll values and sampled buffer addresses come from tilemap_golden.txt
`timescale 1ns/10ps
`include "tilemap_defines.svh"

module tb_tilemap import tilemap_pkg::*;;

    logic clk = 1'b0;
    logic rst;
    logic [7:0] v;
    scroll_regs_s regs;
    logic start, done;
    vram_addr_t vram_addr;
    logic vram_cs, vram_ok;
    logic [15:0] vram_data;
    rom_addr_t rom_addr;
    logic rom_cs, rom_ok;
    gfx_row_t rom_data;
    buf_addr_t rd_addr;
    pixel_t rd_data;

    logic [31:0] delay_state = 32'h86928d88;
    logic rand_delay;
    logic mem_busy;
    logic [1:0] mem_cnt;
    logic [1:0] d;
    int fd, n, errors, test_errors, tests, passed, cnt;
    logic timed_out;
    logic [8*128-1:0] line;
    logic [8*16-1:0] name;
    logic [15:0] in_v, in_base, in_hpos, in_vpos;
    int in_rand;
    logic [8:0] saddr [0:5];
    logic [4:0] spal [0:5];
    pixel_t expected;

    tilemap_top i_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // taps 32,22,2,1
    endfunction

    // tile ROM contents: a scrambled row per address
    function automatic gfx_row_t rom_row(input rom_addr_t a);
        logic [31:0] s;
        s = {9'd0, a} ^ 32'h86928d88;
        repeat (32) s = lfsr_next(s);
        return s;
    endfunction

    task automatic next_delay(output logic [1:0] dl);
        delay_state = lfsr_next(delay_state);
        dl[0] = delay_state[0];
        delay_state = lfsr_next(delay_state);
        dl[1] = delay_state[0];
    endtask

    // colour expected at buffer address a, from the tile, attribute and flip rules
    function automatic logic [3:0] model_colour(input logic [8:0] a, input logic [7:0] vv,
                                                input scroll_regs_s r);
        logic [8:0] k;
        logic [2:0] px, rsel;
        logic [10:0] vn, hn;
        logic [11:0] scan;
        logic [22:0] caddr, aaddr;
        logic [15:0] code;
        logic [6:0] at;
        logic [31:0] row;
        k = a + {6'd0, r.hpos[2:0]};
        px = k[2:0];
        vn = r.vpos[10:0] + {3'd0, vv};
        hn = {r.hpos[10:3], 3'd0} + {2'd0, k[8:3], 3'd0};
        scan = {vn[8], hn[8:3], vn[7:3]};
        caddr = {r.vram_base, 7'd0} + {10'd0, scan, 1'b0};
        code = caddr[15:0] ^ 16'h5a5a;
        aaddr = caddr + 23'd1;
        at = aaddr[6:0];
        rsel = vn[2:0] ^ {3{at[6]}};
        row = rom_row({`ROM_BANK, 1'b0, code, rsel});
        if (at[5])
            return {row[24+px], row[16+px], row[8+px], row[px]};
        return {row[31-px], row[23-px], row[15-px], row[7-px]};
    endfunction

    // shared memory model, only one cs is ever high
    always @(posedge clk) begin
        if (rst) begin
            vram_ok <= 1'b0;
            rom_ok <= 1'b0;
            mem_busy <= 1'b0;
        end else if (vram_ok || rom_ok) begin
            vram_ok <= 1'b0;
            rom_ok <= 1'b0;
        end else if (vram_cs || rom_cs) begin
            d = 2'd0;
            if (mem_busy && mem_cnt != 2'd1) begin
                mem_cnt <= mem_cnt - 2'd1;
            end else begin
                if (!mem_busy && rand_delay)
                    next_delay(d);
                if (d != 2'd0) begin
                    mem_busy <= 1'b1;
                    mem_cnt <= d;
                end else begin
                    mem_busy <= 1'b0;
                    vram_ok <= vram_cs;
                    rom_ok <= rom_cs;
                    vram_data <= vram_cs ? (vram_word_is_attr() ? {9'd0, vram_addr[7:1]}
                                                                : vram_addr[16:1] ^ 16'h5a5a)
                                         : 16'h0;
                    rom_data <= rom_row(rom_addr);
                end
            end
        end
    end

    function automatic logic vram_word_is_attr();
        return vram_addr[1];    // odd word addresses hold attributes
    endfunction

    initial begin
        rst = 1'b1;
        v = '0;
        regs = '0;
        start = 1'b0;
        rd_addr = '0;
        rand_delay = 1'b0;
        vram_data = '0;
        vram_ok = 1'b0;
        rom_data = '0;
        rom_ok = 1'b0;
        mem_cnt = '0;
        errors = 0;
        tests = 0;
        passed = 0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("tilemap_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open tilemap_golden.txt");
            errors = errors + 1;
        end
        while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %h %h %h %h %d %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, in_v, in_base, in_hpos, in_vpos, in_rand,
                        saddr[0], spal[0], saddr[1], spal[1], saddr[2], spal[2],
                        saddr[3], spal[3], saddr[4], spal[4], saddr[5], spal[5]);
            if (n == 18) begin
                tests = tests + 1;
                test_errors = 0;
                @(posedge clk);
                v <= in_v[7:0];
                regs <= '{vram_base: in_base, hpos: in_hpos, vpos: in_vpos};
                rand_delay <= (in_rand != 0);
                start <= 1'b1;
                cnt = 0;
                while (!done && cnt < 20000) begin
                    @(posedge clk);
                    cnt = cnt + 1;
                end
                if (!done) begin
                    $display("test %0s: timeout, done never rose", name);
                    timed_out = 1'b1;
                end else begin
                    start <= 1'b0;
                    cnt = 0;
                    do begin
                        @(posedge clk);
                        cnt = cnt + 1;
                    end while (done && cnt < 100);
                    if (done) begin
                        $display("test %0s: done stayed high after start fell", name);
                        test_errors = test_errors + 1;
                    end
                    for (int i = 0; i < 6; i++) begin
                        @(posedge clk);
                        rd_addr <= saddr[i];
                        @(posedge clk);
                        @(negedge clk);
                        expected = {spal[i], model_colour(saddr[i], in_v[7:0],
                                    '{vram_base: in_base, hpos: in_hpos, vpos: in_vpos})};
                        if (rd_data !== expected) begin
                            $display("FAILED %0s addr %0d expected %h actual %h",
                                     name, saddr[i], expected, rd_data);
                            test_errors = test_errors + 1;
                        end
                    end
                    if (test_errors == 0) begin
                        $display("test %0s: ok", name);
                        passed = passed + 1;
                    end else begin
                        $display("test %0s: %0d errors", name, test_errors);
                    end
                    errors = errors + test_errors;
                end
            end
        end
        $display("tests run %0d, passed %0d, failed %0d", tests, passed, tests - passed);
        if (errors == 0 && !timed_out && tests > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tile_rom_addr.sv */
// holds the tile code and attribute of the tile being fetched
// ROM row address is only valid once both words are latched
`timescale 1ns/10ps
`include "tilemap_defines.svh"

module tile_rom_addr import tilemap_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  pos_t        vn,
    input  logic [15:0] vram_data,
    input  logic        code_load,
    input  logic        attr_load,
    output rom_addr_t   rom_addr,
    output tile_attr_s  attr
);

    logic [15:0] code;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            code <= '0;
            attr <= '0;
        end else begin
            if (code_load) code <= vram_data;
            if (attr_load) attr <= tile_attr_s'(vram_data[6:0]);   // upper bits ignored
        end
    end

    // one 32-bit row per tile line, vflip mirrors the row within the tile
    assign rom_addr = {`ROM_BANK, 1'b0, code, vn[2:0] ^ {3{attr.vflip}}};

endmodule

/* tile_scan_addr.sv */
// scrolled layer position and VRAM address of the current tile
// hn starts on a tile boundary, fine scroll is applied at the buffer
`timescale 1ns/10ps
`include "tilemap_defines.svh"

module tile_scan_addr import tilemap_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic [7:0]   v,
    input  scroll_regs_s regs,
    input  logic         line_load,
    input  logic         tile_step,
    input  logic         vram_word_sel,
    output pos_t         vn,
    output vram_addr_t   vram_addr
);

    pos_t        hn;
    logic [11:0] scan;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vn <= '0;
            hn <= '0;
        end else if (line_load) begin
            vn <= regs.vpos[10:0] + {3'd0, v};
            hn <= {regs.hpos[10:3], 3'd0};          // round down to tile
        end else if (tile_step) begin
            hn <= hn + pos_t'(`TILE_PIX);
        end
    end

    // map is 64 columns by 64 rows, column-major in two 32-row halves
    assign scan = {vn[8], hn[8:3], vn[7:3]};

    // two words per tile, code first then attribute
    assign vram_addr = {regs.vram_base, 7'd0} + {10'd0, scan, vram_word_sel};

endmodule

/* tilemap_ctrl.sv */
// line FSM: code and attribute from VRAM, one ROM row, then 8 draw cycles
// start is a level; done holds until start drops
// memory requests are held until the matching ok pulse
`timescale 1ns/10ps
`include "tilemap_defines.svh"

module tilemap_ctrl import tilemap_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic vram_ok,
    input  logic rom_ok,
    input  logic line_end,
    output logic done,
    output logic vram_cs,
    output logic rom_cs,
    output logic line_load,
    output logic tile_step,
    output logic code_load,
    output logic attr_load,
    output logic vram_word_sel,
    output logic row_load,
    output logic pix_shift
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic [2:0]  draw_cnt;
    logic        draw_last;

    assign draw_last = (draw_cnt == 3'(`TILE_PIX - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start) state_nxt = ST_SCAN;
            end
            ST_SCAN: begin
                state_nxt = ST_CODE;    // scan address settles here
            end
            ST_CODE: begin
                if (vram_ok) state_nxt = ST_ATTR;
            end
            ST_ATTR: begin
                if (vram_ok) state_nxt = ST_ROM;
            end
            ST_ROM: begin
                if (rom_ok) state_nxt = ST_DRAW;
            end
            ST_DRAW: begin
                if (draw_last)
                    state_nxt = line_end ? ST_DONE : ST_SCAN;
            end
            ST_DONE: begin
                if (!start) state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            draw_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_DRAW)
                draw_cnt <= draw_cnt + 3'd1;
            else
                draw_cnt <= '0;
        end
    end

    // strobes decode straight from the state
    assign line_load     = (state == ST_IDLE) && start;
    assign vram_cs       = (state == ST_CODE) || (state == ST_ATTR);
    assign vram_word_sel = (state == ST_ATTR);              // attribute word
    assign code_load     = (state == ST_CODE) && vram_ok;
    assign attr_load     = (state == ST_ATTR) && vram_ok;
    assign rom_cs        = (state == ST_ROM);
    assign row_load      = (state == ST_ROM) && rom_ok;
    assign tile_step     = row_load;                        // next tile column
    assign pix_shift     = (state == ST_DRAW);
    assign done          = (state == ST_DONE);

endmodule

/* tilemap_defines.svh */
// tile layer constants, 8x8 tiles only
// the line buffer depth must stay a power of two for write address wrap
`ifndef TILEMAP_DEFINES_SVH
`define TILEMAP_DEFINES_SVH

// pixels written per raster line
`define LINE_PIXELS 448

// line buffer entries, 9-bit index
`define BUF_DEPTH 512

// tile width and height in pixels
`define TILE_PIX 8

// tile ROM bank id, top 3 address bits
`define ROM_BANK 3'd1

`endif

/* tilemap_golden.txt */
# name v vram_base hpos vpos rand_delay, then six pairs of buffer address and palette (hex)
# expected pixel is {palette, colour}; colour follows the ROM row and flip rules
zero_scroll 10 0000 0000 0000 0 000 05 003 05 007 05 010 05 064 05 1b0 05
flip_bits 88 0000 0000 0000 0 000 03 005 03 008 03 00d 03 0c8 03 12c 03
fine_scroll 20 0000 0005 0000 0 1fb 09 1ff 09 000 09 002 09 12c 09 1c2 09
vert_cross 10 0000 0023 00f8 0 1fd 03 1ff 03 000 03 064 03 190 03 1bc 03
base_rand 55 0123 01a6 0030 1 1fa 01 1ff 01 000 01 001 01 0de 01 1c1 01
base_wrap ff 7f00 0007 0101 1 1f9 01 1ff 01 000 01 040 01 12c 01 1c0 01

/* tilemap_pkg.sv */
// types shared by the scroll layer datapath and its controller
// widths follow an 8x8 tile layer on a 512x512 map
package tilemap_pkg;

    typedef logic [23:1] vram_addr_t;   // word address, byte bit dropped
    typedef logic [22:0] rom_addr_t;    // top 3 bits select the bank
    typedef logic [10:0] pos_t;         // scrolled layer coordinate
    typedef logic [8:0]  buf_addr_t;
    typedef logic [8:0]  pixel_t;       // {pal, colour}
    typedef logic [31:0] gfx_row_t;     // 4 planes x 8 pixels

    typedef struct packed {
        logic [15:0] vram_base;         // map base, in 128-word units
        logic [15:0] hpos;
        logic [15:0] vpos;
    } scroll_regs_s;

    typedef struct packed {
        logic       vflip;              // attr word bit 6
        logic       hflip;              // attr word bit 5
        logic [4:0] pal;
    } tile_attr_s;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SCAN,
        ST_CODE,
        ST_ATTR,
        ST_ROM,
        ST_DRAW,
        ST_DONE
    } ctrl_state_e;

endpackage

/* tilemap_properties.sv */
// controller and memory strobe checks, bound into every tilemap_ctrl
`timescale 1ns/10ps

module tilemap_properties (
    input logic clk,
    input logic rst,
    input logic start,
    input logic done,
    input logic vram_cs,
    input logic rom_cs,
    input logic pix_shift
);

    // one memory request at a time
    a_one_request: assert property (@(posedge clk) disable iff (rst) !(vram_cs && rom_cs))
        else $error("vram_cs and rom_cs high together");

    a_done_held: assert property (@(posedge clk) disable iff (rst) done && start |=> done)
        else $error("done fell while start was still high");

    // each tile draws in one run of exactly 8 shifts
    a_draw_eight: assert property (@(posedge clk) disable iff (rst)
        $fell(pix_shift) |-> $past(pix_shift, 8) && !$past(pix_shift, 9))
        else $error("draw run was not 8 cycles long");

    // async reset clears the FSM, so nothing may be requested
    a_quiet_reset: assert property (@(posedge clk)
        rst |-> !(vram_cs || rom_cs || done || pix_shift))
        else $error("strobe high during reset");

endmodule

bind tilemap_ctrl tilemap_properties i_props (.*);

/* tilemap_top.sv */
// scroll layer renderer, 8x8 tiles, one raster line per start request
// VRAM and ROM are external; each cs is answered by a one-cycle ok pulse
`timescale 1ns/10ps

module tilemap_top import tilemap_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic [7:0]   v,
    input  scroll_regs_s regs,
    input  logic         start,
    output logic         done,
    output vram_addr_t   vram_addr,
    output logic         vram_cs,
    input  logic [15:0]  vram_data,
    input  logic         vram_ok,
    output rom_addr_t    rom_addr,
    output logic         rom_cs,
    input  gfx_row_t     rom_data,
    input  logic         rom_ok,
    input  buf_addr_t    rd_addr,
    output pixel_t       rd_data
);

    logic       line_load;
    logic       tile_step;
    logic       code_load;
    logic       attr_load;
    logic       vram_word_sel;
    logic       row_load;
    logic       pix_shift;
    logic       line_end;
    logic       buf_wr;
    pos_t       vn;
    tile_attr_s attr;
    buf_addr_t  buf_addr;
    pixel_t     buf_data;

    tilemap_ctrl i_ctrl (
        .clk, .rst, .start, .vram_ok, .rom_ok, .line_end,
        .done, .vram_cs, .rom_cs, .line_load, .tile_step,
        .code_load, .attr_load, .vram_word_sel, .row_load, .pix_shift
    );

    tile_scan_addr i_scan (
        .clk, .rst, .v, .regs, .line_load, .tile_step, .vram_word_sel,
        .vn, .vram_addr
    );

    tile_rom_addr i_rom_addr (
        .clk, .rst, .vn, .vram_data, .code_load, .attr_load,
        .rom_addr, .attr
    );

    pixel_unpacker i_unpack (
        .clk, .rst, .regs, .line_load, .row_load, .pix_shift, .rom_data, .attr,
        .buf_wr, .buf_addr, .buf_data, .line_end
    );

    line_buffer i_buf (
        .clk, .buf_wr, .buf_addr, .buf_data, .rd_addr, .rd_data
    );

endmodule

/* vlog.f */
+incdir+.
tilemap_pkg.sv
tile_scan_addr.sv
tile_rom_addr.sv
pixel_unpacker.sv
line_buffer.sv
tilemap_ctrl.sv
tilemap_top.sv
tilemap_properties.sv
tb_tilemap.sv
